// File: hdl/memPkg.sv
// memPkg: widths, encodings and stage payloads shared by the memory pipeline
package memPkg;

    localparam int addrW     = 32;
    localparam int dataW     = 32;
    localparam int ramWords  = 256;
    localparam int ramAddrW  = $clog2(ramWords);  // word index into the RAM
    localparam int fetchCntW = 16;                // words per fetch burst

    // value written back to the register file
    typedef enum logic [1:0] {
        pcLink  = 2'd0,  // jal/jalr link address
        aluOut  = 2'd1,
        outB    = 2'd2,  // moves from hi/lo/cp0 side
        memLoad = 2'd3
    } wbSelE;

    // access size of a load or store
    typedef enum logic [1:0] {
        byteS = 2'd0,
        halfS = 2'd1,
        wordS = 2'd2
    } loadSizeE;

    // execute to MEM
    typedef struct packed {
        logic                 valid;
        logic [addrW-1:0]     pc;
        logic [dataW-1:0]     aluOut;   // also the data address
        logic [dataW-1:0]     outB;     // store data / move source
        logic [4:0]           dst;
        logic                 regWr;
        wbSelE                wbSel;
        logic                 isLoad;
        logic                 isStore;
        loadSizeE             size;
        logic                 signExt;
    } exMemS;

    // MEM to MEM2, keeps the byte offset for load extraction
    typedef struct packed {
        logic                 valid;
        logic [addrW-1:0]     pc;
        logic [dataW-1:0]     aluOut;
        logic [dataW-1:0]     outB;
        logic [4:0]           dst;
        logic                 regWr;
        wbSelE                wbSel;
        logic                 isLoad;
        logic                 isStore;
        loadSizeE             size;
        logic                 signExt;
        logic [1:0]           offset;
    } memMem2S;

    // MEM2 to WB
    typedef struct packed {
        logic                 valid;
        logic [4:0]           dst;
        logic                 regWr;
        logic [dataW-1:0]     data;
    } mem2WbS;

    // one request on the shared memory bus
    typedef struct packed {
        logic                 req;
        logic                 we;
        logic [addrW-1:0]     addr;    // word aligned
        logic [dataW-1:0]     wdata;
        logic [3:0]           byteEn;
    } busReqS;

endpackage

// File: hdl/busArbiter.sv
// busArbiter: round-robin grant of the shared memory bus to the data or fetch port
module busArbiter (
    input  logic            clk,
    input  logic            rstN,
    input  memPkg::busReqS  dataReq,
    input  memPkg::busReqS  fetchReq,
    output logic            dataGrant,
    output logic            fetchGrant,
    output memPkg::busReqS  ramReq
);

    logic fetchLast;  // last winner was the fetch port

    // data port wins when alone, or when fetch had the previous turn
    assign dataGrant  = dataReq.req & (~fetchReq.req | fetchLast);
    assign fetchGrant = fetchReq.req & (~dataReq.req | ~fetchLast);  // fetch alone or its turn

    always_comb begin
        ramReq     = fetchGrant ? fetchReq : dataReq;
        ramReq.req = dataGrant | fetchGrant;
    end

    // reset value gives the data port first pick
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchLast <= 1'b1;
        end else if (dataGrant) begin
            fetchLast <= 1'b0;
        end else if (fetchGrant) begin
            fetchLast <= 1'b1;
        end
    end

    // at most one requester owns the RAM in a cycle
    grantOneHot: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0({dataGrant, fetchGrant})
    ) else $error("busArbiter: both grants high");

    // a refused requester keeps its request steady until granted
    dataHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        (dataReq.req && !dataGrant) |=> $stable(dataReq)
    ) else $error("busArbiter: data request changed while waiting");

    fetchHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        (fetchReq.req && !fetchGrant) |=> $stable(fetchReq)
    ) else $error("busArbiter: fetch request changed while waiting");

endmodule

// File: hdl/dataRam.sv
// dataRam: word-wide synchronous RAM with byte-lane writes and one-cycle read latency
module dataRam (
    input  logic                     clk,
    input  memPkg::busReqS           ramReq,
    output logic [memPkg::dataW-1:0] rdata
);

    logic [memPkg::dataW-1:0]    mem [memPkg::ramWords];
    logic [memPkg::ramAddrW-1:0] wordIdx;

    // upper address bits wrap onto the array
    assign wordIdx = ramReq.addr[memPkg::ramAddrW+1:2];

    // byte lanes, only those flagged in byteEn change
    always_ff @(posedge clk) begin
        if (ramReq.req && ramReq.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (ramReq.byteEn[lane]) begin
                    mem[wordIdx][8*lane +: 8] <= ramReq.wdata[8*lane +: 8];
                end
            end
        end
    end

    // read word stays put until the next granted read
    always_ff @(posedge clk) begin
        if (ramReq.req && !ramReq.we) begin
            rdata <= mem[wordIdx];
        end
    end

endmodule

// File: hdl/memStage.sv
// memStage: aligns loads and stores onto the shared bus and holds the MEM to MEM2 register
module memStage (
    input  logic              clk,
    input  logic              rstN,
    input  memPkg::exMemS     exIn,
    input  logic              grant,
    output memPkg::busReqS    busReq,
    output logic              exStall,
    output memPkg::memMem2S   memOut
);

    logic [1:0]      offset;
    logic            needBus;
    logic [3:0]      laneMask;
    logic            memValid;
    memPkg::memMem2S memNext;
    memPkg::memMem2S memPay;

    assign offset  = exIn.aluOut[1:0];
    assign needBus = exIn.valid & (exIn.isLoad | exIn.isStore);
    assign exStall = needBus & ~grant;  // wait for the bus, execute holds exIn

    // store lanes by size
    always_comb begin
        case (exIn.size)
            memPkg::byteS: laneMask = 4'b0001 << offset;
            memPkg::halfS: laneMask = 4'b0011 << offset;
            default:       laneMask = 4'b1111;
        endcase
    end

    always_comb begin
        busReq.req    = needBus;
        busReq.we     = exIn.isStore;
        busReq.addr   = {exIn.aluOut[memPkg::addrW-1:2], 2'b00};
        busReq.wdata  = exIn.outB << {offset, 3'b000};  // move data into its lanes
        busReq.byteEn = exIn.isStore ? laneMask : 4'b1111;
    end

    always_comb begin
        memNext.valid   = exIn.valid;
        memNext.pc      = exIn.pc;
        memNext.aluOut  = exIn.aluOut;
        memNext.outB    = exIn.outB;
        memNext.dst     = exIn.dst;
        memNext.regWr   = exIn.regWr;
        memNext.wbSel   = exIn.wbSel;
        memNext.isLoad  = exIn.isLoad;
        memNext.isStore = exIn.isStore;
        memNext.size    = exIn.size;
        memNext.signExt = exIn.signExt;
        memNext.offset  = offset;
    end

    // a waiting access sends a bubble on to MEM2
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memValid <= 1'b0;
        end else begin
            memValid <= exIn.valid & ~exStall;
        end
    end

    always_ff @(posedge clk) begin
        if (!exStall) begin
            memPay <= memNext;
        end
    end

    always_comb begin
        memOut       = memPay;
        memOut.valid = memValid;
    end

    // alignment that execute must guarantee
    halfAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        (exIn.valid && exIn.isStore && exIn.size == memPkg::halfS) |-> !offset[0]
    ) else $error("memStage: unaligned halfword store");

    wordAligned: assert property (
        @(posedge clk) disable iff (!rstN)
        (needBus && exIn.size == memPkg::wordS) |-> (offset == 2'b00)
    ) else $error("memStage: unaligned word access");

endmodule

// File: hdl/mem2Stage.sv
// mem2Stage: MEM2 register, load extraction, forwarding mux and the MEM2 to WB register
module mem2Stage (
    input  logic                     clk,
    input  logic                     rstN,
    input  memPkg::memMem2S          memIn,
    input  logic                     mem2Flush,
    input  logic [memPkg::dataW-1:0] rdata,
    output logic [memPkg::dataW-1:0] mem2Result,
    output logic [4:0]               mem2Dst,
    output logic                     mem2RegWr,
    output memPkg::mem2WbS           wbOut
);

    logic                     mem2Valid;
    memPkg::memMem2S          mem2R;
    logic [memPkg::dataW-1:0] loadWordR;  // raw RAM word for a load
    logic [7:0]               loadByte;
    logic [15:0]              loadHalf;
    logic [memPkg::dataW-1:0] loadData;
    logic                     wbValid;
    logic [4:0]               wbDst;
    logic                     wbRegWr;
    logic [memPkg::dataW-1:0] wbData;

    // flush drops the entry moving into MEM2
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mem2Valid <= 1'b0;
        end else begin
            mem2Valid <= memIn.valid & ~mem2Flush;
        end
    end

    always_ff @(posedge clk) begin
        mem2R <= memIn;
        if (memIn.valid && memIn.isLoad) begin
            loadWordR <= rdata;  // read data lands one cycle after the grant
        end
    end

    // addressed byte and halfword
    always_comb begin
        case (mem2R.offset)
            2'd0:    loadByte = loadWordR[7:0];
            2'd1:    loadByte = loadWordR[15:8];
            2'd2:    loadByte = loadWordR[23:16];
            default: loadByte = loadWordR[31:24];
        endcase
        loadHalf = mem2R.offset[1] ? loadWordR[31:16] : loadWordR[15:0];
    end

    always_comb begin
        case (mem2R.size)
            memPkg::byteS: loadData = {{24{mem2R.signExt & loadByte[7]}}, loadByte};
            memPkg::halfS: loadData = {{16{mem2R.signExt & loadHalf[15]}}, loadHalf};
            default:       loadData = loadWordR;
        endcase
    end

    // forwarding value, also what gets written back
    always_comb begin
        case (mem2R.wbSel)
            memPkg::pcLink: mem2Result = mem2R.pc + 'd8;
            memPkg::aluOut: mem2Result = mem2R.aluOut;
            memPkg::outB:   mem2Result = mem2R.outB;
            default:        mem2Result = loadData;
        endcase
    end

    assign mem2Dst   = mem2R.dst;
    assign mem2RegWr = mem2Valid & mem2R.regWr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= mem2Valid;
        end
    end

    always_ff @(posedge clk) begin
        wbDst   <= mem2R.dst;
        wbRegWr <= mem2R.regWr;
        wbData  <= mem2Result;
    end

    assign wbOut = '{valid: wbValid, dst: wbDst, regWr: wbRegWr, data: wbData};

    // decode must pair the load flag with the load writeback source
    loadSelMatch: assert property (
        @(posedge clk) disable iff (!rstN)
        mem2Valid |-> ((mem2R.wbSel == memPkg::memLoad) == mem2R.isLoad)
    ) else $error("mem2Stage: wbSel and isLoad disagree");

endmodule

// File: hdl/fetchPort.sv
// fetchPort: streams consecutive instruction words from a start address over the shared bus
module fetchPort (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         fetchStart,
    input  logic [memPkg::addrW-1:0]     fetchAddr,
    input  logic [memPkg::fetchCntW-1:0] fetchCount,
    input  logic                         grant,
    input  logic [memPkg::dataW-1:0]     rdata,
    output memPkg::busReqS               busReq,
    output logic                         instrValid,
    output logic [memPkg::dataW-1:0]     instr,
    output logic                         fetchBusy
);

    logic [memPkg::addrW-1:0]     addrR;
    logic [memPkg::fetchCntW-1:0] remainR;  // words still to request
    logic                         pendR;    // granted word due on rdata

    always_comb begin
        busReq.req    = (remainR != '0);
        busReq.we     = 1'b0;
        busReq.addr   = addrR;
        busReq.wdata  = '0;
        busReq.byteEn = 4'b1111;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrR   <= '0;
            remainR <= '0;
            pendR   <= 1'b0;
        end else begin
            pendR <= grant;
            if (fetchStart) begin
                addrR   <= {fetchAddr[memPkg::addrW-1:2], 2'b00};
                remainR <= fetchCount;
            end else if (grant) begin
                addrR   <= addrR + 'd4;     // next word
                remainR <= remainR - 1'b1;
            end
        end
    end

    assign instrValid = pendR;
    assign instr      = rdata;
    assign fetchBusy  = busReq.req | pendR;  // drops once the last word is out

endmodule

// File: hdl/memTop.sv
// memTop: memory stages and fetch streamer sharing one RAM through the bus arbiter
module memTop (
    input  logic                         clk,
    input  logic                         rstN,
    input  memPkg::exMemS                exIn,
    output logic                         exStall,
    input  logic                         mem2Flush,
    output logic [memPkg::dataW-1:0]     mem2Result,
    output logic [4:0]                   mem2Dst,
    output logic                         mem2RegWr,
    output memPkg::mem2WbS               wbOut,
    input  logic                         fetchStart,
    input  logic [memPkg::addrW-1:0]     fetchAddr,
    input  logic [memPkg::fetchCntW-1:0] fetchCount,
    output logic                         instrValid,
    output logic [memPkg::dataW-1:0]     instr,
    output logic                         fetchBusy
);

    memPkg::busReqS           dataReq;
    memPkg::busReqS           fetchReq;
    memPkg::busReqS           ramReq;
    logic                     dataGrant;
    logic                     fetchGrant;
    logic [memPkg::dataW-1:0] rdata;      // shared by both requesters
    memPkg::memMem2S          memToMem2;

    memStage u_memStage (
        .clk     (clk),
        .rstN    (rstN),
        .exIn    (exIn),
        .grant   (dataGrant),
        .busReq  (dataReq),
        .exStall (exStall),
        .memOut  (memToMem2)
    );

    mem2Stage u_mem2Stage (
        .clk        (clk),
        .rstN       (rstN),
        .memIn      (memToMem2),
        .mem2Flush  (mem2Flush),
        .rdata      (rdata),
        .mem2Result (mem2Result),
        .mem2Dst    (mem2Dst),
        .mem2RegWr  (mem2RegWr),
        .wbOut      (wbOut)
    );

    fetchPort u_fetchPort (
        .clk        (clk),
        .rstN       (rstN),
        .fetchStart (fetchStart),
        .fetchAddr  (fetchAddr),
        .fetchCount (fetchCount),
        .grant      (fetchGrant),
        .rdata      (rdata),
        .busReq     (fetchReq),
        .instrValid (instrValid),
        .instr      (instr),
        .fetchBusy  (fetchBusy)
    );

    busArbiter u_busArbiter (
        .clk        (clk),
        .rstN       (rstN),
        .dataReq    (dataReq),
        .fetchReq   (fetchReq),
        .dataGrant  (dataGrant),
        .fetchGrant (fetchGrant),
        .ramReq     (ramReq)
    );

    dataRam u_dataRam (
        .clk    (clk),
        .ramReq (ramReq),
        .rdata  (rdata)
    );

endmodule

// File: tb/memTopTb.sv
// memTopTb: file-driven testbench for the memory pipeline and fetch streamer
module memTopTb;

    logic                         clk;
    logic                         rstN;
    memPkg::exMemS                exIn;
    logic                         exStall;
    logic                         mem2Flush;
    logic [memPkg::dataW-1:0]     mem2Result;
    logic [4:0]                   mem2Dst;
    logic                         mem2RegWr;
    memPkg::mem2WbS               wbOut;
    logic                         fetchStart;
    logic [memPkg::addrW-1:0]     fetchAddr;
    logic [memPkg::fetchCntW-1:0] fetchCount;
    logic                         instrValid;
    logic [memPkg::dataW-1:0]     instr;
    logic                         fetchBusy;

    logic [memPkg::dataW-1:0] refMem [memPkg::ramWords];  // reference memory
    memPkg::mem2WbS           expQ [$];
    int                       cycQ [$];   // acceptance cycle of each queued entry
    string                    nameQ [$];
    int                       cycleCnt = 0;
    int                       wbErrs = 0;
    int                       wordErrs = 0;
    int                       otherErrs = 0;
    logic                     fetchActive = 1'b0;
    logic [memPkg::dataW-1:0] prevResult;
    logic [4:0]               prevDst;
    logic                     prevRegWr;
    integer                   seed = 32'hbbad_20c0;

    memTop i_dut (
        .clk(clk), .rstN(rstN), .exIn(exIn), .exStall(exStall), .mem2Flush(mem2Flush),
        .mem2Result(mem2Result), .mem2Dst(mem2Dst), .mem2RegWr(mem2RegWr), .wbOut(wbOut),
        .fetchStart(fetchStart), .fetchAddr(fetchAddr), .fetchCount(fetchCount),
        .instrValid(instrValid), .instr(instr), .fetchBusy(fetchBusy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    task automatic timedOut(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic checkWb(input string name, input memPkg::mem2WbS exp,
                           input memPkg::mem2WbS act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            wbErrs++;
        end
    endtask

    task automatic checkWord(input string name, input logic [memPkg::dataW-1:0] exp,
                             input logic [memPkg::dataW-1:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            wordErrs++;
        end
    endtask

    // lane-masked store into the reference memory
    task automatic modelStore(input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] size);
        int off;
        off = int'(addr[1:0]);
        case (size)
            2'd0:    refMem[addr[9:2]][8*off +: 8] = data[7:0];
            2'd1:    refMem[addr[9:2]][8*off +: 16] = data[15:0];
            default: refMem[addr[9:2]] = data;
        endcase
    endtask

    function automatic logic [31:0] modelLoad(input logic [31:0] addr, input logic [1:0] size,
                                              input logic sext);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = refMem[addr[9:2]];
        b = word >> (8 * addr[1:0]);
        h = word >> (8 * addr[1:0]);
        case (size)
            2'd0:    return {{24{sext & b[7]}}, b};
            2'd1:    return {{16{sext & h[15]}}, h};
            default: return word;
        endcase
    endfunction

    // entered on a falling edge, leaves on the falling edge after acceptance
    task automatic driveOp(input memPkg::exMemS op, input memPkg::mem2WbS expE,
                           input string name, input logic flushIt, input logic [1:0] size);
        int waitCnt;
        waitCnt = 0;
        exIn = op;
        #1;
        while (exStall) begin
            waitCnt++;
            if (waitCnt > 40) timedOut("a bus grant for the data port");
            @(negedge clk);
            mem2Flush = 1'b0;
            #1;
        end
        if (op.isStore) modelStore(op.aluOut, op.outB, size);
        if (!flushIt) begin
            expQ.push_back(expE);
            cycQ.push_back(cycleCnt + 1);
            nameQ.push_back(name);
        end
        @(negedge clk);
        exIn = '0;
        mem2Flush = flushIt;  // drops the entry as it moves into MEM2
    endtask

    task automatic runFetch(input logic [31:0] addr, input int count, input int delay);
        int waitCnt;
        repeat (delay) @(negedge clk);
        fetchStart = 1'b1;
        fetchAddr  = addr;
        fetchCount = count[memPkg::fetchCntW-1:0];
        @(negedge clk);
        fetchStart = 1'b0;
        for (int i = 0; i < count; i++) begin
            waitCnt = 0;
            while (!instrValid) begin
                waitCnt++;
                if (waitCnt > 60) timedOut("a fetched word");
                @(negedge clk);
            end
            checkWord($sformatf("fetch %h", addr + 4 * i), refMem[addr[9:2] + 8'(i)], instr);
            @(negedge clk);
        end
        if (fetchBusy) begin
            $display("fetchBusy still high after the last fetched word");
            otherErrs++;
        end
        fetchActive = 1'b0;
    endtask

    // writeback and forwarding monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rstN && wbOut.valid) begin
            if (expQ.size() == 0) begin
                $display("writeback seen with no instruction outstanding, dst %0d", wbOut.dst);
                otherErrs++;
            end else begin
                checkWb(nameQ[0], expQ[0], wbOut);
                checkWord({nameQ[0], " fwd"}, expQ[0].data, prevResult);
                checkWord({nameQ[0], " fwd dst"}, 32'(expQ[0].dst), 32'(prevDst));
                checkWord({nameQ[0], " fwd regWr"}, 32'(expQ[0].regWr), 32'(prevRegWr));
                if (cycleCnt != cycQ[0] + 2) begin
                    $display("ERR %s wb cycle expected %0d actual %0d",
                             nameQ[0], cycQ[0] + 2, cycleCnt);
                    otherErrs++;
                end
                void'(expQ.pop_front());
                void'(cycQ.pop_front());
                void'(nameQ.pop_front());
            end
        end
        prevResult = mem2Result;
        prevDst    = mem2Dst;
        prevRegWr  = mem2RegWr;
    end

    initial begin
        int             fd;
        int             code;
        int             lineNo;
        int             waitCnt;
        string          line;
        byte            kind;
        logic [31:0]    pc;
        logic [31:0]    alu;
        logic [31:0]    b;
        logic [31:0]    exp;
        logic [31:0]    mdl;
        logic [4:0]     dst;
        logic [1:0]     size;
        logic           sext;
        logic           flushIt;
        logic [31:0]    fetchFrom;
        int             fetchNum;
        int             fetchDelay;
        memPkg::exMemS  op;
        memPkg::mem2WbS expE;
        exIn = '0;
        mem2Flush = 1'b0;
        fetchStart = 1'b0;
        fetchAddr = '0;
        fetchCount = '0;
        rstN = 1'b0;
        lineNo = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        fd = $fopen("tb/memTop_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file");
            otherErrs++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                lineNo++;
                if (line.len() < 2 || line.getc(0) == 8'h23) continue;  // comments
                code = $sscanf(line, "%c %h %h %h %h %h %h %h %h",
                               kind, pc, alu, b, dst, size, sext, flushIt, exp);
                if (code != 9) begin
                    $display("test data line %0d could not be parsed", lineNo);
                    otherErrs++;
                    continue;
                end
                if (kind == "F") begin
                    waitCnt = 0;
                    while (fetchActive) begin
                        waitCnt++;
                        if (waitCnt > 200) timedOut("the previous fetch to finish");
                        @(negedge clk);
                        mem2Flush = 1'b0;
                    end
                    fetchActive = 1'b1;
                    // held until this fetch clears fetchActive
                    fetchFrom  = alu;
                    fetchNum   = int'(b);
                    fetchDelay = size[0] ? ($random(seed) & 7) : 0;
                    fork
                        runFetch(fetchFrom, fetchNum, fetchDelay);
                    join_none
                    continue;
                end
                op = '0;
                op.valid = 1'b1;
                op.pc = pc;
                op.aluOut = alu;
                op.outB = b;
                op.dst = dst;
                op.regWr = (kind != "S");
                op.size = memPkg::loadSizeE'(size);
                op.signExt = sext;
                case (kind)
                    "S": begin
                        op.isStore = 1'b1;
                        op.wbSel = memPkg::aluOut;
                        mdl = alu;
                    end
                    "L": begin
                        op.isLoad = 1'b1;
                        op.wbSel = memPkg::memLoad;
                        mdl = modelLoad(alu, size, sext);
                    end
                    "K": begin
                        op.wbSel = memPkg::pcLink;
                        mdl = pc + 32'd8;
                    end
                    "B": begin
                        op.wbSel = memPkg::outB;
                        mdl = b;
                    end
                    default: begin
                        op.wbSel = memPkg::aluOut;
                        mdl = alu;
                    end
                endcase
                if (mdl !== exp) begin
                    $display("test data line %0d lists %h but the model gives %h",
                             lineNo, exp, mdl);
                    otherErrs++;
                end
                expE = '{valid: 1'b1, dst: dst, regWr: op.regWr, data: mdl};
                driveOp(op, expE, $sformatf("line%0d", lineNo), flushIt, size);
            end
            $fclose(fd);
        end
        // drain the pipeline and any fetch still running
        waitCnt = 0;
        while (expQ.size() != 0 || fetchActive) begin
            waitCnt++;
            if (waitCnt > 300) timedOut("the pipeline and fetch to drain");
            @(negedge clk);
            mem2Flush = 1'b0;
        end
        repeat (4) @(negedge clk);
        $display("errors: writeback %0d, word %0d, other %0d", wbErrs, wordErrs, otherErrs);
        if (wbErrs + wordErrs + otherErrs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/memTop_testdata.txt
# kind pc aluOut outB dst size(0 byte, 1 half, 2 word) signExt flush expected, all hex
# kinds S store, L load, K link, A aluOut, B outB, F fetch (aluOut start, outB count, size 1 random start)
S 00000100 00000040 11223344 00 2 0 0 00000040
S 00000104 00000044 8899aabb 00 2 0 0 00000044
S 00000108 00000048 cafef00d 00 2 0 0 00000048
S 0000010c 0000004c 0badbeef 00 2 0 0 0000004c
S 00000110 00000080 00000000 00 2 0 0 00000080
S 00000114 00000082 0000f234 00 1 0 0 00000082
S 00000118 00000081 000000a5 00 0 0 0 00000081
L 0000011c 00000080 00000000 03 2 0 0 f234a500
L 00000120 00000081 00000000 04 0 1 0 ffffffa5
L 00000124 00000081 00000000 05 0 0 0 000000a5
L 00000128 00000082 00000000 06 1 1 0 fffff234
L 0000012c 00000082 00000000 07 1 0 0 0000f234
K 00000130 00000000 00000000 1f 2 0 0 00000138
A 00000134 12345678 00000000 08 2 0 0 12345678
B 00000138 00000000 5a5a5a5a 09 2 0 0 5a5a5a5a
F 00000000 00000040 00000004 00 1 0 0 00000000
L 0000013c 00000044 00000000 0a 2 0 0 8899aabb
A 00000140 00000111 00000000 0b 2 0 1 00000111
A 00000144 00000222 00000000 0c 2 0 0 00000222
L 00000148 00000083 00000000 0d 0 1 0 fffffff2
F 00000000 00000048 00000002 00 0 0 0 00000000
L 0000014c 00000040 00000000 0e 2 0 0 11223344
A 00000150 00000333 00000000 0f 2 0 0 00000333

// File: src.f
hdl/memPkg.sv
hdl/busArbiter.sv
hdl/dataRam.sv
hdl/memStage.sv
hdl/mem2Stage.sv
hdl/fetchPort.sv
hdl/memTop.sv
tb/memTopTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module memTopTb -f src.f > build.log 2>&1 \
    && ./obj_dir/VmemTopTb > sim.log 2>&1 \
    || echo "Simulation finished: FAIL" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }
